// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" &&
	verilator --binary --timing -f vlog.f --top-module fpga_ctrl_tb -o fpga_ctrl_sim &&
	./obj_dir/fpga_ctrl_sim | tee /dev/stderr | grep -q "TB PASSED" &&
	echo "Simulation passed" ||
	{ echo "Simulation failed"; exit 1; }

// File: source/fpga_ctrl_top.sv
//////////////////////////////
// Link FPGA control block top level
// SPI slave and packet decoder feeding the register bank
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fpga_ctrl_top
	import reg_map_pkg::*, link_cfg_pkg::*;
(
	input wire CLK_IN,
	input wire RESET_IN,
	input wire spi_cs_n,
	input wire spi_sclk,
	input wire spi_mosi,
	output logic spi_miso,
	input wire lc_pkt_valid,
	input wire reg_data_t lc_pkt_key,
	input wire reg_data_t lc_pkt_payload,
	input wire reg_data_t version,
	input wire flags_t flags,
	output reg_data_t link_enable,
	output logic [3:0] scrmbl_idle_data,
	output logic [7:0] led_override,
	output logic periph_in_en,
	output serdes_cfg_t serdes_cfg,
	output route_cfg_t route_cfg
);

	reg_write_t spi_wr;
	lc_write_t lc_wr;
	reg_addr_t rd_addr;
	reg_data_t rd_data;

	spi_reg_slave spi_reg_slave_inst (
		.CLK_IN(CLK_IN),
		.RESET_IN(RESET_IN),
		.spi_cs_n(spi_cs_n),
		.spi_sclk(spi_sclk),
		.spi_mosi(spi_mosi),
		.spi_miso(spi_miso),
		.spi_wr(spi_wr),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

	// Match against the committed key and mask
	lc_packet_decoder lc_packet_decoder_inst (
		.CLK_IN(CLK_IN),
		.RESET_IN(RESET_IN),
		.lc_pkt_valid(lc_pkt_valid),
		.lc_pkt_key(lc_pkt_key),
		.lc_pkt_payload(lc_pkt_payload),
		.lc_key(route_cfg.lc_key),
		.lc_mask(route_cfg.lc_mask),
		.lc_wr(lc_wr)
	);

	fpga_reg_bank fpga_reg_bank_inst (
		.CLK_IN(CLK_IN),
		.RESET_IN(RESET_IN),
		.spi_wr(spi_wr),
		.lc_wr(lc_wr),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.version(version),
		.flags(flags),
		.link_enable(link_enable),
		.scrmbl_idle_data(scrmbl_idle_data),
		.led_override(led_override),
		.periph_in_en(periph_in_en),
		.serdes_cfg(serdes_cfg),
		.route_cfg(route_cfg)
	);

endmodule

`default_nettype wire

// File: source/fpga_reg_bank.sv
//////////////////////////////
// Control and diagnostic register bank
// Written from SPI and local configuration packets and read over SPI
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fpga_reg_bank
	import reg_map_pkg::*, link_cfg_pkg::*;
(
	input wire CLK_IN,
	input wire RESET_IN,
	input wire reg_write_t spi_wr,
	input wire lc_write_t lc_wr,
	input wire reg_addr_t rd_addr,
	output reg_data_t rd_data,
	input wire reg_data_t version,
	input wire flags_t flags,
	output reg_data_t link_enable,
	output logic [3:0] scrmbl_idle_data,
	output logic [7:0] led_override,
	output logic periph_in_en,
	output serdes_cfg_t serdes_cfg,
	output route_cfg_t route_cfg
);

	reg_addr_t lc_addr;
	logic lkey_write;
	// Staged mask committed on the next key write
	reg_data_t lc_mask_hold;

	assign lc_addr = reg_addr_t'(lc_wr.addr);
	assign lkey_write = (lc_wr.valid && lc_addr == LKEY_REG) ||
		(spi_wr.valid && spi_wr.addr == LKEY_REG);

	// Link and transceiver settings written by SPI only
	always_ff @(posedge CLK_IN or posedge RESET_IN)
		if (RESET_IN)
		begin
			link_enable <= LINKEN_DEF;
			scrmbl_idle_data <= SCRMBL_DEF;
			led_override <= LEDOVR_DEF;
			serdes_cfg.rxeqmix <= RXEQ_DEF;
			serdes_cfg.txdiffctrl <= TXDS_DEF;
			serdes_cfg.txpreemphasis <= TXPE_DEF;
		end
		else if (spi_wr.valid)
			case (spi_wr.addr)
				SCRM_REG: scrmbl_idle_data <= spi_wr.data[3:0];
				SLEN_REG: link_enable <= spi_wr.data;
				LEDO_REG: led_override <= spi_wr.data[7:0];
				RXEQ_REG: serdes_cfg.rxeqmix <= spi_wr.data[7:0];
				TXDS_REG: serdes_cfg.txdiffctrl <= spi_wr.data[15:0];
				TXPE_REG: serdes_cfg.txpreemphasis <= spi_wr.data[11:0];
				default: ;
			endcase

	// Routing keys and peripheral enable written by both sources
	always_ff @(posedge CLK_IN or posedge RESET_IN)
		if (RESET_IN)
		begin
			route_cfg.periph_key <= PKEY_DEF;
			route_cfg.periph_mask <= PMSK_DEF;
			route_cfg.lc_key <= LKEY_DEF;
			route_cfg.lc_mask <= LMSK_DEF;
			route_cfg.rc_key <= RKEY_DEF;
			route_cfg.rc_mask <= RMSK_DEF;
			lc_mask_hold <= LMSK_DEF;
			periph_in_en <= PINE_DEF;
		end
		else
		begin
			// Key write commits the staged mask (old value if both land together)
			if (lkey_write)
				route_cfg.lc_mask <= lc_mask_hold;

			if (spi_wr.valid)
				case (spi_wr.addr)
					PKEY_REG: route_cfg.periph_key <= spi_wr.data;
					PMSK_REG: route_cfg.periph_mask <= spi_wr.data;
					LKEY_REG: route_cfg.lc_key <= spi_wr.data;
					LMSK_REG: lc_mask_hold <= spi_wr.data;
					RKEY_REG: route_cfg.rc_key <= spi_wr.data;
					RMSK_REG: route_cfg.rc_mask <= spi_wr.data;
					PIND_REG: periph_in_en <= 1'b0;
					PINE_REG: periph_in_en <= 1'b1;
					default: ;
				endcase

			// Packet writes come last and win a shared address
			if (lc_wr.valid)
				case (lc_addr)
					PKEY_REG: route_cfg.periph_key <= lc_wr.data;
					PMSK_REG: route_cfg.periph_mask <= lc_wr.data;
					LKEY_REG: route_cfg.lc_key <= lc_wr.data;
					LMSK_REG: lc_mask_hold <= lc_wr.data;
					RKEY_REG: route_cfg.rc_key <= lc_wr.data;
					RMSK_REG: route_cfg.rc_mask <= lc_wr.data;
					PIND_REG: periph_in_en <= 1'b0;
					PINE_REG: periph_in_en <= 1'b1;
					default: ;
				endcase
		end

	// Read mux
	always_comb
		case (rd_addr)
			VERS_REG: rd_data = version;
			FLAG_REG: rd_data = reg_data_t'(flags);
			PKEY_REG: rd_data = route_cfg.periph_key;
			PMSK_REG: rd_data = route_cfg.periph_mask;
			SCRM_REG: rd_data = reg_data_t'(scrmbl_idle_data);
			SLEN_REG: rd_data = link_enable;
			LEDO_REG: rd_data = reg_data_t'(led_override);
			RXEQ_REG: rd_data = reg_data_t'(serdes_cfg.rxeqmix);
			TXDS_REG: rd_data = reg_data_t'(serdes_cfg.txdiffctrl);
			TXPE_REG: rd_data = reg_data_t'(serdes_cfg.txpreemphasis);
			LKEY_REG: rd_data = route_cfg.lc_key;
			// Committed mask rather than the staged one
			LMSK_REG: rd_data = route_cfg.lc_mask;
			RKEY_REG: rd_data = route_cfg.rc_key;
			RMSK_REG: rd_data = route_cfg.rc_mask;
			PIND_REG: rd_data = reg_data_t'(periph_in_en);
			PINE_REG: rd_data = reg_data_t'(periph_in_en);
			default: rd_data = UNMAPPED_READ;
		endcase

endmodule

`default_nettype wire

// File: source/lc_packet_decoder.sv
//////////////////////////////
// Local configuration packet decoder
// Keys matching lc_key under lc_mask become register writes
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module lc_packet_decoder
	import reg_map_pkg::*, link_cfg_pkg::*;
(
	input wire CLK_IN,
	input wire RESET_IN,
	input wire lc_pkt_valid,
	input wire reg_data_t lc_pkt_key,
	input wire reg_data_t lc_pkt_payload,
	input wire reg_data_t lc_key,
	input wire reg_data_t lc_mask,
	output lc_write_t lc_wr
);

	// Input stage
	logic pkt_valid_q;
	reg_data_t pkt_key_q;
	reg_data_t pkt_payload_q;
	// Output stage
	logic wr_valid;
	lc_addr_t wr_addr;
	reg_data_t wr_data;
	logic key_match;

	assign key_match = (pkt_key_q & lc_mask) == lc_key;

	always_ff @(posedge CLK_IN or posedge RESET_IN)
		if (RESET_IN)
		begin
			pkt_valid_q <= 1'b0;
			wr_valid <= 1'b0;
		end
		else
		begin
			pkt_valid_q <= lc_pkt_valid;
			// Misses just vanish
			wr_valid <= pkt_valid_q && key_match;
		end

	always_ff @(posedge CLK_IN)
	begin
		if (lc_pkt_valid)
		begin
			pkt_key_q <= lc_pkt_key;
			pkt_payload_q <= lc_pkt_payload;
		end
		if (pkt_valid_q)
		begin
			// Register index sits in the key's low byte
			wr_addr <= pkt_key_q[7:0];
			wr_data <= pkt_payload_q;
		end
	end

	assign lc_wr = '{valid: wr_valid, addr: wr_addr, data: wr_data};

endmodule

`default_nettype wire

// File: source/link_cfg_pkg.sv
//////////////////////////////
// Grouped signals of the link control block
// Write strobes and the configuration bundles sent to the link logic
//////////////////////////////
`default_nettype none

package link_cfg_pkg;

	import reg_map_pkg::*;

	// Register write from the SPI port
	typedef struct packed {
		logic valid;
		reg_addr_t addr;
		reg_data_t data;
	} reg_write_t;

	// Register write decoded from a local configuration packet
	typedef struct packed {
		logic valid;
		lc_addr_t addr;
		reg_data_t data;
	} lc_write_t;

	// Transceiver analog settings, each {ring, periph, b2b1, b2b0}
	typedef struct packed {
		logic [7:0] rxeqmix;
		logic [15:0] txdiffctrl;
		logic [11:0] txpreemphasis;
	} serdes_cfg_t;

	// Multicast keys and masks used by the packet router
	typedef struct packed {
		// Peripheral traffic
		reg_data_t periph_key;
		reg_data_t periph_mask;
		// Local configuration packets, mask is the committed copy
		reg_data_t lc_key;
		reg_data_t lc_mask;
		// Remote configuration packets
		reg_data_t rc_key;
		reg_data_t rc_mask;
	} route_cfg_t;

endpackage

`default_nettype wire

// File: source/reg_map_pkg.sv
//////////////////////////////
// Register map of the link control block
// Widths, addresses and reset defaults shared by RTL and testbench
//////////////////////////////
`default_nettype none

package reg_map_pkg;

	// Register port widths
	typedef logic [13:0] reg_addr_t;
	typedef logic [31:0] reg_data_t;
	// Address field of a local configuration packet
	typedef logic [7:0] lc_addr_t;
	// Compile flags {chipscope, periph, ring, north/south front, fpga id[1:0]}
	typedef logic [5:0] flags_t;

	// SPI frame layout, header first
	localparam int SPI_HDR_BITS = 16;
	localparam int SPI_FRAME_BITS = SPI_HDR_BITS + 32;
	typedef logic [$clog2(SPI_FRAME_BITS)-1:0] spi_cnt_t;

	// Register addresses
	localparam reg_addr_t VERS_REG = 14'd0;
	localparam reg_addr_t FLAG_REG = 14'd1;
	localparam reg_addr_t PKEY_REG = 14'd2;
	localparam reg_addr_t PMSK_REG = 14'd3;
	localparam reg_addr_t SCRM_REG = 14'd4;
	localparam reg_addr_t SLEN_REG = 14'd5;
	localparam reg_addr_t LEDO_REG = 14'd6;
	localparam reg_addr_t RXEQ_REG = 14'd7;
	localparam reg_addr_t TXDS_REG = 14'd8;
	localparam reg_addr_t TXPE_REG = 14'd9;
	// Routing registers, also reachable by packets
	localparam reg_addr_t LKEY_REG = 14'd12;
	localparam reg_addr_t LMSK_REG = 14'd13;
	localparam reg_addr_t RKEY_REG = 14'd14;
	localparam reg_addr_t RMSK_REG = 14'd15;
	// Write-only clear and set of the peripheral input enable
	localparam reg_addr_t PIND_REG = 14'd16;
	localparam reg_addr_t PINE_REG = 14'd17;

	// Reset defaults
	localparam reg_data_t PKEY_DEF = 32'hffff_ffff;
	localparam reg_data_t PMSK_DEF = 32'h0000_0000;
	localparam logic [3:0] SCRMBL_DEF = 4'hf;
	localparam reg_data_t LINKEN_DEF = 32'h0000_0000;
	// Dim nothing, force error on all links
	localparam logic [7:0] LEDOVR_DEF = 8'h0f;
	localparam logic PINE_DEF = 1'b0;
	localparam reg_data_t LKEY_DEF = 32'hffff_fe00;
	localparam reg_data_t LMSK_DEF = 32'hffff_ff00;
	localparam reg_data_t RKEY_DEF = 32'hffff_ff00;
	localparam reg_data_t RMSK_DEF = 32'hffff_ff00;

	// Per-link transceiver analog settings, ring link left at zero
	localparam logic [1:0] B2B_RXEQMIX = 2'b10;
	localparam logic [1:0] PERIPH_RXEQMIX = 2'b10;
	localparam logic [1:0] RING_RXEQMIX = 2'b00;
	localparam logic [3:0] B2B_TXDIFFCTRL = 4'b0110;
	localparam logic [3:0] PERIPH_TXDIFFCTRL = 4'b0110;
	localparam logic [3:0] RING_TXDIFFCTRL = 4'b0000;
	localparam logic [2:0] B2B_TXPREEMPHASIS = 3'b010;
	localparam logic [2:0] PERIPH_TXPREEMPHASIS = 3'b010;
	localparam logic [2:0] RING_TXPREEMPHASIS = 3'b000;

	// Packed as {ring, periph, b2b1, b2b0}
	localparam logic [7:0] RXEQ_DEF =
		{RING_RXEQMIX, PERIPH_RXEQMIX, B2B_RXEQMIX, B2B_RXEQMIX};
	localparam logic [15:0] TXDS_DEF =
		{RING_TXDIFFCTRL, PERIPH_TXDIFFCTRL, B2B_TXDIFFCTRL, B2B_TXDIFFCTRL};
	localparam logic [11:0] TXPE_DEF =
		{RING_TXPREEMPHASIS, PERIPH_TXPREEMPHASIS, B2B_TXPREEMPHASIS, B2B_TXPREEMPHASIS};

	// Read value of any address outside the map
	localparam reg_data_t UNMAPPED_READ = '1;

endpackage

`default_nettype wire

// File: source/spi_reg_slave.sv
//////////////////////////////
// SPI slave of the register bank
// 16 bit header {wr, rsvd, addr[13:0]} then 32 data bits, MSB first
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module spi_reg_slave
	import reg_map_pkg::*, link_cfg_pkg::*;
(
	input wire CLK_IN,
	input wire RESET_IN,
	input wire spi_cs_n,
	input wire spi_sclk,
	input wire spi_mosi,
	output logic spi_miso,
	output reg_write_t spi_wr,
	output reg_addr_t rd_addr,
	input wire reg_data_t rd_data
);

	typedef enum logic [1:0] {ST_IDLE, ST_HEADER, ST_DATA, ST_COMMIT} spi_state_t;

	spi_state_t state;
	// Two sync flops plus one for edge detect
	logic [2:0] sclk_sync;
	logic [2:0] cs_sync;
	// Extra stage lines MOSI up with the registered SCLK edge
	logic [2:0] mosi_sync;
	logic sclk_rise;
	logic sclk_fall;
	logic cs_fall;
	logic cs_high;
	logic mosi_bit;
	logic shift_en;
	logic hdr_done;
	spi_cnt_t bit_cnt;
	logic load_rd;
	logic wr_flag;
	logic wr_valid;
	reg_data_t rx_sr;
	reg_data_t tx_sr;

	assign cs_high = cs_sync[1];
	assign cs_fall = cs_sync[2] & ~cs_sync[1];
	assign mosi_bit = mosi_sync[2];
	assign shift_en = sclk_rise && (state == ST_HEADER || state == ST_DATA);
	assign hdr_done = sclk_rise && state == ST_HEADER &&
		bit_cnt == spi_cnt_t'(SPI_HDR_BITS - 1);

	// Pin synchronizers and registered SCLK edges
	always_ff @(posedge CLK_IN or posedge RESET_IN)
		if (RESET_IN)
		begin
			sclk_sync <= '0;
			cs_sync <= '1;
			mosi_sync <= '0;
			sclk_rise <= 1'b0;
			sclk_fall <= 1'b0;
		end
		else
		begin
			sclk_sync <= {sclk_sync[1:0], spi_sclk};
			cs_sync <= {cs_sync[1:0], spi_cs_n};
			mosi_sync <= {mosi_sync[1:0], spi_mosi};
			sclk_rise <= sclk_sync[1] & ~sclk_sync[2];
			sclk_fall <= ~sclk_sync[1] & sclk_sync[2];
		end

	// Frame FSM
	always_ff @(posedge CLK_IN or posedge RESET_IN)
		if (RESET_IN)
		begin
			state <= ST_IDLE;
			bit_cnt <= '0;
			load_rd <= 1'b0;
			wr_valid <= 1'b0;
			spi_miso <= 1'b0;
		end
		else
		begin
			load_rd <= 1'b0;
			wr_valid <= 1'b0;
			case (state)
				ST_IDLE:
				begin
					spi_miso <= 1'b0;
					bit_cnt <= '0;
					if (cs_fall)
						state <= ST_HEADER;
				end
				ST_HEADER:
					// CS raised mid-frame drops it
					if (cs_high)
						state <= ST_IDLE;
					else if (sclk_rise)
					begin
						bit_cnt <= bit_cnt + 1'b1;
						if (hdr_done)
						begin
							load_rd <= 1'b1;
							state <= ST_DATA;
						end
					end
				ST_DATA:
					if (cs_high)
						state <= ST_IDLE;
					else
					begin
						// Read word goes out on falling edges
						if (sclk_fall)
							spi_miso <= tx_sr[31];
						if (sclk_rise)
						begin
							bit_cnt <= bit_cnt + 1'b1;
							if (bit_cnt == spi_cnt_t'(SPI_FRAME_BITS - 1))
								state <= ST_COMMIT;
						end
					end
				ST_COMMIT:
				begin
					// Single strobe, reads only drop back to idle
					wr_valid <= wr_flag;
					state <= ST_IDLE;
				end
				default:
					state <= ST_IDLE;
			endcase
		end

	// Shift registers and latched header
	always_ff @(posedge CLK_IN)
	begin
		if (shift_en)
			rx_sr <= {rx_sr[30:0], mosi_bit};
		if (hdr_done)
		begin
			// Fifteen header bits are already in, the last one is on MOSI
			wr_flag <= rx_sr[14];
			rd_addr <= {rx_sr[12:0], mosi_bit};
		end
		if (load_rd)
			tx_sr <= rd_data;
		else if (state == ST_DATA && sclk_fall)
			tx_sr <= {tx_sr[30:0], 1'b0};
	end

	assign spi_wr = '{valid: wr_valid, addr: rd_addr, data: rx_sr};

endmodule

`default_nettype wire

// File: tests/fpga_ctrl_tb.sv
//////////////////////////////
// Testbench of the link control block
// Random SPI frames and packets checked against a register model
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fpga_ctrl_tb
	import reg_map_pkg::*, link_cfg_pkg::*;
();

	// SCLK half period in clock cycles, the slave's minimum
	localparam int SPI_HALF = 3;
	// Header and data bits plus the closing fall and CS gap
	localparam int FRAME_CYCLES = 2 * SPI_HALF * (SPI_FRAME_BITS + 1);
	// Packet drive point so its write lands with the SPI strobe
	localparam int PKT_OFFSET = (2 * SPI_FRAME_BITS - 1) * SPI_HALF + 3;
	localparam int RAND_FRAMES = 200;
	localparam int RAND_PACKETS = 40;
	localparam int TIMEOUT_CYCLES = 2 * (RAND_FRAMES + 60) * FRAME_CYCLES;

	logic CLK_IN;
	logic RESET_IN;
	logic spi_cs_n;
	logic spi_sclk;
	logic spi_mosi;
	logic spi_miso;
	logic lc_pkt_valid;
	reg_data_t lc_pkt_key;
	reg_data_t lc_pkt_payload;
	reg_data_t version;
	flags_t flags;
	reg_data_t link_enable;
	logic [3:0] scrmbl_idle_data;
	logic [7:0] led_override;
	logic periph_in_en;
	serdes_cfg_t serdes_cfg;
	route_cfg_t route_cfg;

	// Register model, LMSK entry is the committed mask
	reg_data_t m_reg [reg_addr_t];
	reg_data_t m_hold;
	logic m_pine;
	integer seed;
	int cycle_count = 0;

	fpga_ctrl_top fpga_ctrl_top_inst (
		.CLK_IN(CLK_IN),
		.RESET_IN(RESET_IN),
		.spi_cs_n(spi_cs_n),
		.spi_sclk(spi_sclk),
		.spi_mosi(spi_mosi),
		.spi_miso(spi_miso),
		.lc_pkt_valid(lc_pkt_valid),
		.lc_pkt_key(lc_pkt_key),
		.lc_pkt_payload(lc_pkt_payload),
		.version(version),
		.flags(flags),
		.link_enable(link_enable),
		.scrmbl_idle_data(scrmbl_idle_data),
		.led_override(led_override),
		.periph_in_en(periph_in_en),
		.serdes_cfg(serdes_cfg),
		.route_cfg(route_cfg)
	);

	initial
		CLK_IN = 1'b0;

	always #10 CLK_IN = ~CLK_IN;

	// Run limit
	always @(posedge CLK_IN)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TB FAILED");
			$fatal(1, "Simulation stopped");
		end
	end

	task automatic check_value(input string name, input reg_data_t actual,
		input reg_data_t expected);
		if (actual !== expected)
		begin
			$display("** Error: %s is 0x%h, expected 0x%h", name, actual, expected);
			$display("TB FAILED");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	// Advance to just after a later rising edge
	task automatic step(input int n);
		repeat (n) @(posedge CLK_IN);
		#1;
	endtask

	task automatic model_reset();
		m_reg[PKEY_REG] = PKEY_DEF;
		m_reg[PMSK_REG] = PMSK_DEF;
		m_reg[SCRM_REG] = reg_data_t'(SCRMBL_DEF);
		m_reg[SLEN_REG] = LINKEN_DEF;
		m_reg[LEDO_REG] = reg_data_t'(LEDOVR_DEF);
		m_reg[RXEQ_REG] = reg_data_t'(RXEQ_DEF);
		m_reg[TXDS_REG] = reg_data_t'(TXDS_DEF);
		m_reg[TXPE_REG] = reg_data_t'(TXPE_DEF);
		m_reg[LKEY_REG] = LKEY_DEF;
		m_reg[LMSK_REG] = LMSK_DEF;
		m_reg[RKEY_REG] = RKEY_DEF;
		m_reg[RMSK_REG] = RMSK_DEF;
		m_hold = LMSK_DEF;
		m_pine = 1'b0;
	endtask

	// Routing registers and the enable pair
	function automatic logic lc_writable(input reg_addr_t a);
		return a inside {PKEY_REG, PMSK_REG, LKEY_REG, LMSK_REG,
			RKEY_REG, RMSK_REG, PIND_REG, PINE_REG};
	endfunction

	function automatic logic key_hits(input reg_data_t key);
		return (key & m_reg[LMSK_REG]) == m_reg[LKEY_REG];
	endfunction

	function automatic reg_data_t expected_read(input reg_addr_t a);
		case (a)
			VERS_REG: return version;
			FLAG_REG: return reg_data_t'(flags);
			PIND_REG, PINE_REG: return reg_data_t'(m_pine);
			PKEY_REG, PMSK_REG, SCRM_REG, SLEN_REG, LEDO_REG, RXEQ_REG, TXDS_REG,
			TXPE_REG, LKEY_REG, LMSK_REG, RKEY_REG, RMSK_REG: return m_reg[a];
			default: return 32'hffff_ffff;
		endcase
	endfunction

	task automatic model_write(input reg_addr_t a, input reg_data_t d);
		case (a)
			PKEY_REG, PMSK_REG, SLEN_REG, LKEY_REG, RKEY_REG, RMSK_REG: m_reg[a] = d;
			SCRM_REG: m_reg[a] = d & 32'h0000_000f;
			LEDO_REG, RXEQ_REG: m_reg[a] = d & 32'h0000_00ff;
			TXDS_REG: m_reg[a] = d & 32'h0000_ffff;
			TXPE_REG: m_reg[a] = d & 32'h0000_0fff;
			// Staged until the next key write
			LMSK_REG: m_hold = d;
			PIND_REG: m_pine = 1'b0;
			PINE_REG: m_pine = 1'b1;
			default: ;
		endcase
	endtask

	// One clock of writes from both sources
	task automatic model_cycle(input logic spi_v, input reg_addr_t spi_a,
		input reg_data_t spi_d, input logic lc_v, input reg_addr_t lc_a, input reg_data_t lc_d);
		reg_data_t old_hold;
		logic key_wr;
		old_hold = m_hold;
		key_wr = (spi_v && spi_a == LKEY_REG) || (lc_v && lc_a == LKEY_REG);
		// Packet wins a shared address
		if (spi_v && !(lc_v && lc_a == spi_a && lc_writable(lc_a)))
			model_write(spi_a, spi_d);
		if (lc_v && lc_writable(lc_a))
			model_write(lc_a, lc_d);
		if (key_wr)
			m_reg[LMSK_REG] = old_hold;
	endtask

	task automatic check_outputs();
		check_value("link_enable", link_enable, m_reg[SLEN_REG]);
		check_value("scrmbl_idle_data", reg_data_t'(scrmbl_idle_data), m_reg[SCRM_REG]);
		check_value("led_override", reg_data_t'(led_override), m_reg[LEDO_REG]);
		check_value("periph_in_en", reg_data_t'(periph_in_en), reg_data_t'(m_pine));
		check_value("serdes_cfg.rxeqmix", reg_data_t'(serdes_cfg.rxeqmix), m_reg[RXEQ_REG]);
		check_value("serdes_cfg.txdiffctrl", reg_data_t'(serdes_cfg.txdiffctrl),
			m_reg[TXDS_REG]);
		check_value("serdes_cfg.txpreemphasis", reg_data_t'(serdes_cfg.txpreemphasis),
			m_reg[TXPE_REG]);
		check_value("route_cfg.periph_key", route_cfg.periph_key, m_reg[PKEY_REG]);
		check_value("route_cfg.periph_mask", route_cfg.periph_mask, m_reg[PMSK_REG]);
		check_value("route_cfg.lc_key", route_cfg.lc_key, m_reg[LKEY_REG]);
		check_value("route_cfg.lc_mask", route_cfg.lc_mask, m_reg[LMSK_REG]);
		check_value("route_cfg.rc_key", route_cfg.rc_key, m_reg[RKEY_REG]);
		check_value("route_cfg.rc_mask", route_cfg.rc_mask, m_reg[RMSK_REG]);
	endtask

	// Mode 0 frame, MOSI set with each fall, MISO sampled just before the next fall
	task automatic spi_frame(input logic wr, input reg_addr_t addr, input reg_data_t wdata,
		output reg_data_t rdata);
		logic [47:0] frame;
		int i;
		frame = {wr, 1'b0, addr, wdata};
		rdata = '0;
		spi_cs_n = 1'b0;
		for (i = 0; i < SPI_FRAME_BITS; i = i + 1)
		begin
			// Read word starts one fall after the header
			if (i > SPI_HDR_BITS)
				rdata = {rdata[30:0], spi_miso};
			spi_mosi = frame[47];
			frame = {frame[46:0], 1'b0};
			spi_sclk = 1'b0;
			step(SPI_HALF);
			spi_sclk = 1'b1;
			step(SPI_HALF);
		end
		rdata = {rdata[30:0], spi_miso};
		spi_sclk = 1'b0;
		step(SPI_HALF);
		spi_cs_n = 1'b1;
		step(SPI_HALF);
	endtask

	// Frame plus readback check, write frames return the old word
	task automatic spi_access(input logic wr, input reg_addr_t addr, input reg_data_t data);
		reg_data_t expected;
		reg_data_t word;
		expected = expected_read(addr);
		spi_frame(wr, addr, data, word);
		check_value($sformatf("spi_miso word of 0x%h", addr), word, expected);
		if (wr)
			model_cycle(1'b1, addr, data, 1'b0, '0, '0);
		check_outputs();
	endtask

	// Key that hits or misses the current local key and mask
	task automatic make_key(input lc_addr_t a, input logic hit, output reg_data_t key);
		key = (m_reg[LKEY_REG] & m_reg[LMSK_REG]) |
			(reg_data_t'($random(seed)) & ~m_reg[LMSK_REG]);
		key[7:0] = a;
		if (!hit)
			key = key ^ 32'h8000_0000;
	endtask

	task automatic send_packet(input reg_data_t key, input reg_data_t payload);
		logic hit;
		hit = key_hits(key);
		lc_pkt_key = key;
		lc_pkt_payload = payload;
		lc_pkt_valid = 1'b1;
		step(1);
		lc_pkt_valid = 1'b0;
		// Decoder stage then register
		step(2);
		if (hit)
			model_cycle(1'b0, '0, '0, 1'b1, reg_addr_t'(key[7:0]), payload);
		check_outputs();
	endtask

	task automatic send_pair(input reg_data_t key_a, input reg_data_t pay_a,
		input reg_data_t key_b, input reg_data_t pay_b);
		logic hit_a;
		logic hit_b;
		hit_a = key_hits(key_a);
		hit_b = key_hits(key_b);
		lc_pkt_key = key_a;
		lc_pkt_payload = pay_a;
		lc_pkt_valid = 1'b1;
		step(1);
		lc_pkt_key = key_b;
		lc_pkt_payload = pay_b;
		step(1);
		lc_pkt_valid = 1'b0;
		step(2);
		if (hit_a)
			model_cycle(1'b0, '0, '0, 1'b1, reg_addr_t'(key_a[7:0]), pay_a);
		if (hit_b)
			model_cycle(1'b0, '0, '0, 1'b1, reg_addr_t'(key_b[7:0]), pay_b);
		check_outputs();
	endtask

	// SPI write and packet write landing on the same clock
	task automatic collide_writes(input reg_addr_t spi_addr, input reg_data_t spi_data,
		input lc_addr_t pkt_addr, input reg_data_t payload);
		reg_data_t key;
		reg_data_t word;
		reg_data_t expected;
		logic hit;
		make_key(pkt_addr, 1'b1, key);
		hit = key_hits(key);
		expected = expected_read(spi_addr);
		fork
			spi_frame(1'b1, spi_addr, spi_data, word);
			begin
				step(PKT_OFFSET);
				lc_pkt_key = key;
				lc_pkt_payload = payload;
				lc_pkt_valid = 1'b1;
				step(1);
				lc_pkt_valid = 1'b0;
			end
		join
		check_value("spi_miso word", word, expected);
		model_cycle(1'b1, spi_addr, spi_data, hit, reg_addr_t'(pkt_addr), payload);
		check_outputs();
		spi_access(1'b0, spi_addr, '0);
		spi_access(1'b0, reg_addr_t'(pkt_addr), '0);
	endtask

	initial
	begin
		reg_data_t key;
		reg_data_t key2;
		reg_addr_t addr;
		logic [4:0] pick;
		logic [2:0] sel;
		lc_addr_t pkt_addrs [8];
		int i;
		seed = 4;
		RESET_IN = 1'b1;
		spi_cs_n = 1'b1;
		spi_sclk = 1'b0;
		spi_mosi = 1'b0;
		lc_pkt_valid = 1'b0;
		lc_pkt_key = '0;
		lc_pkt_payload = '0;
		version = reg_data_t'($random(seed));
		flags = flags_t'($random(seed));
		// Packet targets, SCRM and 0x30 are not packet writable
		pkt_addrs = '{8'd2, 8'd3, 8'd14, 8'd15, 8'd16, 8'd17, 8'd4, 8'h30};
		repeat (2) @(posedge CLK_IN);
		#1 RESET_IN = 1'b0;
		model_reset();
		step(2);

		// Reset state and defaults
		check_value("spi_miso", reg_data_t'(spi_miso), '0);
		check_value("spi_wr.valid", reg_data_t'(fpga_ctrl_top_inst.spi_wr.valid), '0);
		check_value("lc_wr.valid", reg_data_t'(fpga_ctrl_top_inst.lc_wr.valid), '0);
		check_outputs();
		for (i = 0; i < 18; i = i + 1)
			spi_access(1'b0, reg_addr_t'(i), '0);
		spi_access(1'b0, 14'h3fff, '0);

		// Random SPI frames, a few far outside the map
		for (i = 0; i < RAND_FRAMES; i = i + 1)
		begin
			pick = 5'($random(seed));
			addr = (pick < 5'd24) ? reg_addr_t'(pick) : reg_addr_t'($random(seed));
			spi_access(1'($random(seed)), addr, reg_data_t'($random(seed)));
		end
		spi_access(1'b1, PINE_REG, '0);
		check_value("periph_in_en", reg_data_t'(periph_in_en), 32'd1);
		spi_access(1'b1, PIND_REG, '0);
		check_value("periph_in_en", reg_data_t'(periph_in_en), 32'd0);

		// Packets, alternating hits and misses
		spi_access(1'b1, LMSK_REG, LMSK_DEF);
		spi_access(1'b1, LKEY_REG, LKEY_DEF);
		for (i = 0; i < RAND_PACKETS; i = i + 1)
		begin
			sel = 3'($random(seed));
			make_key(pkt_addrs[sel], (i % 2) == 0, key);
			send_packet(key, reg_data_t'($random(seed)));
		end
		make_key(lc_addr_t'(RKEY_REG), 1'b1, key);
		make_key(lc_addr_t'(RMSK_REG), 1'b1, key2);
		send_pair(key, reg_data_t'($random(seed)), key2, reg_data_t'($random(seed)));
		for (i = 2; i < 18; i = i + 1)
			spi_access(1'b0, reg_addr_t'(i), '0);

		// Staged mask over SPI
		spi_access(1'b1, LMSK_REG, 32'hffff_0000);
		check_value("route_cfg.lc_mask", route_cfg.lc_mask, LMSK_DEF);
		spi_access(1'b0, LMSK_REG, '0);
		spi_access(1'b1, LKEY_REG, 32'h5a5a_0000);
		check_value("route_cfg.lc_mask", route_cfg.lc_mask, 32'hffff_0000);
		spi_access(1'b0, LMSK_REG, '0);
		// Same through packets
		make_key(lc_addr_t'(LMSK_REG), 1'b1, key);
		send_packet(key, 32'hffff_ff00);
		check_value("route_cfg.lc_mask", route_cfg.lc_mask, 32'hffff_0000);
		make_key(lc_addr_t'(LKEY_REG), 1'b1, key);
		send_packet(key, 32'hffff_fe00);
		check_value("route_cfg.lc_mask", route_cfg.lc_mask, 32'hffff_ff00);
		spi_access(1'b0, LMSK_REG, '0);

		// Collisions
		collide_writes(RKEY_REG, 32'h1111_2222, lc_addr_t'(RKEY_REG), 32'h3333_4444);
		check_value("route_cfg.rc_key", route_cfg.rc_key, 32'h3333_4444);
		collide_writes(PKEY_REG, 32'h5555_6666, lc_addr_t'(RMSK_REG), 32'h7777_8888);
		check_value("route_cfg.periph_key", route_cfg.periph_key, 32'h5555_6666);
		check_value("route_cfg.rc_mask", route_cfg.rc_mask, 32'h7777_8888);
		collide_writes(LKEY_REG, 32'h0bad_0000, lc_addr_t'(LKEY_REG), 32'hffff_fe00);
		check_value("route_cfg.lc_key", route_cfg.lc_key, 32'hffff_fe00);

		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
source/reg_map_pkg.sv
source/link_cfg_pkg.sv
source/spi_reg_slave.sv
source/lc_packet_decoder.sv
source/fpga_reg_bank.sv
source/fpga_ctrl_top.sv
tests/fpga_ctrl_tb.sv
